//--- verilog/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // Frame size kept small for simulation
    localparam int WIDTH = 16;
    localparam int HEIGHT = 12;

    // Gray pixel width
    localparam int PIXEL_BITS = 8;

    // Width of weighted sum and of weight sum
    localparam int ACC_BITS = 16;

    // 5x5 Gaussian kernel whose weights sum to 159
    localparam logic [3:0] KERNEL [0:4][0:4] = '{
        '{4'd2, 4'd4, 4'd5, 4'd4, 4'd2},
        '{4'd4, 4'd9, 4'd12, 4'd9, 4'd4},
        '{4'd5, 4'd12, 4'd15, 4'd12, 4'd5},
        '{4'd4, 4'd9, 4'd12, 4'd9, 4'd4},
        '{4'd2, 4'd4, 4'd5, 4'd4, 4'd2}
    };

    typedef logic [PIXEL_BITS-1:0] pixel_t;

    // Red in the top byte and blue in the bottom byte
    typedef struct packed {
        pixel_t r;
        pixel_t g;
        pixel_t b;
    } rgb_t;

endpackage

`default_nettype wire

//--- verilog/fifo.sv
`default_nettype none

module fifo #(
    parameter type T = logic [7:0],
    parameter int DEPTH = 8
) (
    input  logic clock,
    input  logic reset,
    input  logic wr_en,
    input  T     din,
    output logic full,
    input  logic rd_en,
    output T     dout,
    output logic empty
);

    localparam int ADDR_BITS = $clog2(DEPTH);

    // Storage for the queued words
    T mem [DEPTH];

    // Pointers carry one extra wrap bit
    logic [ADDR_BITS:0] wr_ptr;
    logic [ADDR_BITS:0] rd_ptr;

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr[ADDR_BITS-1:0]] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Head word falls through to the output
    assign dout = mem[rd_ptr[ADDR_BITS-1:0]];

    // Same address on the same lap means empty
    assign empty = (wr_ptr == rd_ptr);

    // Same address with the writer one lap ahead means full
    assign full = (wr_ptr[ADDR_BITS] != rd_ptr[ADDR_BITS])
               && (wr_ptr[ADDR_BITS-1:0] == rd_ptr[ADDR_BITS-1:0]);

endmodule

`default_nettype wire

//--- verilog/grayscale.sv
`default_nettype none

module grayscale
    import blur_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  rgb_t   in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output pixel_t out_din
);

    // Two spare bits hold the sum of three bytes
    localparam int SUM_BITS = PIXEL_BITS + 2;

    logic [SUM_BITS-1:0] channel_sum;
    pixel_t gray;

    // One converted word waiting for the gray FIFO
    logic pending;

    assign channel_sum = SUM_BITS'(in_dout.r)
                       + SUM_BITS'(in_dout.g)
                       + SUM_BITS'(in_dout.b);

    // Truncating average of the three channels
    assign gray = pixel_t'(channel_sum / SUM_BITS'(3));

    // Read only while the output side has room
    assign in_rd_en = !in_empty && !out_full;

    // Pending word goes out as soon as the FIFO accepts it
    assign out_wr_en = pending && !out_full;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (in_rd_en) begin
            // New word replaces the one written this cycle
            pending <= 1'b1;
        end else if (out_wr_en) begin
            pending <= 1'b0;
        end
    end

    // Gray value held under back-pressure
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_din <= gray;
        end
    end

endmodule

`default_nettype wire

//--- verilog/gaussian_blur.sv
`default_nettype none

module gaussian_blur
    import blur_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  pixel_t in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output pixel_t out_din
);

    // Pixels needed before the first centre reaches the middle tap
    localparam int PROLOGUE_LEN = 2 * WIDTH + 3;
    localparam int SHIFT_LEN = 4 * WIDTH + 5;
    localparam int PIXEL_COUNT = WIDTH * HEIGHT;
    localparam int CNT_BITS = $clog2(PROLOGUE_LEN);
    localparam int COL_BITS = $clog2(WIDTH);
    localparam int ROW_BITS = $clog2(HEIGHT);

    // FSM encoding
    localparam logic [1:0] PROLOGUE = 2'd0;
    localparam logic [1:0] FILTER = 2'd1;
    localparam logic [1:0] OUTPUT = 2'd2;

    logic [1:0] state, state_c;
    logic [CNT_BITS-1:0] counter, counter_c;

    // Row and column of the current window centre
    logic [COL_BITS-1:0] col, col_c;
    logic [ROW_BITS-1:0] row, row_c;

    // Oldest pixel at index 0 and newest at the end
    pixel_t [0:SHIFT_LEN-1] shift_reg;
    logic shift_en;
    pixel_t shift_in;

    logic [ACC_BITS-1:0] numerator, numerator_c;
    logic [ACC_BITS-1:0] denominator, denominator_c;
    logic [ACC_BITS-1:0] quotient;

    logic last_pixel;
    logic pad_zero;

    assign last_pixel = (row == ROW_BITS'(HEIGHT - 1)) && (col == COL_BITS'(WIDTH - 1));

    // Next pixel to shift lies past the end of the frame
    assign pad_zero = (int'(row) * WIDTH + int'(col)) >= (PIXEL_COUNT - PROLOGUE_LEN);

    // Combinational divide
    // Centre weight always counts so the divisor is never zero
    assign quotient = numerator / denominator;
    assign out_din = (quotient > ACC_BITS'(255)) ? '1 : quotient[PIXEL_BITS-1:0];

    always_comb begin
        state_c = state;
        counter_c = counter;
        col_c = col;
        row_c = row;
        shift_en = 1'b0;
        shift_in = '0;
        in_rd_en = 1'b0;
        out_wr_en = 1'b0;

        case (state)
            PROLOGUE: begin
                // Fill until pixel 0 sits at the window centre
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    shift_en = 1'b1;
                    shift_in = in_dout;
                    if (counter == CNT_BITS'(PROLOGUE_LEN - 1)) begin
                        counter_c = '0;
                        state_c = FILTER;
                    end else begin
                        counter_c = counter + 1'b1;
                    end
                end
            end
            FILTER: begin
                state_c = OUTPUT;
            end
            OUTPUT: begin
                // Stall on a full FIFO or on a pixel that has not arrived yet
                if (!out_full && (last_pixel || pad_zero || !in_empty)) begin
                    out_wr_en = 1'b1;
                    if (last_pixel) begin
                        // Frame done so the next frame starts over
                        row_c = '0;
                        col_c = '0;
                        state_c = PROLOGUE;
                    end else begin
                        shift_en = 1'b1;
                        // Zeros past the frame end and real pixels otherwise
                        if (!pad_zero) begin
                            in_rd_en = 1'b1;
                            shift_in = in_dout;
                        end
                        if (col == COL_BITS'(WIDTH - 1)) begin
                            col_c = '0;
                            row_c = row + 1'b1;
                        end else begin
                            col_c = col + 1'b1;
                        end
                        state_c = FILTER;
                    end
                end
            end
            default: begin
                state_c = PROLOGUE;
            end
        endcase
    end

    // Weighted sum over taps inside the image only
    always_comb begin
        int tap_row;
        int tap_col;
        numerator_c = '0;
        denominator_c = '0;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                tap_row = int'(row) + i - 2;
                tap_col = int'(col) + j - 2;
                if (tap_row >= 0 && tap_row < HEIGHT && tap_col >= 0 && tap_col < WIDTH) begin
                    numerator_c = numerator_c
                                + ACC_BITS'(shift_reg[WIDTH * i + j]) * ACC_BITS'(KERNEL[i][j]);
                    denominator_c = denominator_c + ACC_BITS'(KERNEL[i][j]);
                end
            end
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= PROLOGUE;
            counter <= '0;
            col <= '0;
            row <= '0;
        end else begin
            state <= state_c;
            counter <= counter_c;
            col <= col_c;
            row <= row_c;
        end
    end

    // Window data and sums
    always_ff @(posedge clock) begin
        if (shift_en) begin
            shift_reg <= {shift_reg[1:SHIFT_LEN-1], shift_in};
        end
        if (state == FILTER) begin
            numerator <= numerator_c;
            denominator <= denominator_c;
        end
    end

endmodule

`default_nettype wire

//--- verilog/blur_top.sv
`default_nettype none

module blur_top
    import blur_pkg::*;
(
    input  logic   clock,
    input  logic   reset,
    input  logic   in_wr_en,
    output logic   in_full,
    input  rgb_t   in_din,
    input  logic   out_rd_en,
    output logic   out_empty,
    output pixel_t out_dout
);

    // Input FIFO to grayscale
    logic   rgb_rd_en;
    logic   rgb_empty;
    rgb_t   rgb_dout;

    // Grayscale to gray FIFO
    logic   gray_wr_en;
    logic   gray_full;
    pixel_t gray_din;

    // Gray FIFO to blur
    logic   gray_rd_en;
    logic   gray_empty;
    pixel_t gray_dout;

    // Blur to output FIFO
    logic   blur_wr_en;
    logic   blur_full;
    pixel_t blur_din;

    fifo #(
        .T     (rgb_t),
        .DEPTH (8)
    ) in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (rgb_rd_en),
        .dout  (rgb_dout),
        .empty (rgb_empty)
    );

    grayscale grayscale (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (rgb_rd_en),
        .in_empty  (rgb_empty),
        .in_dout   (rgb_dout),
        .out_wr_en (gray_wr_en),
        .out_full  (gray_full),
        .out_din   (gray_din)
    );

    // Deeper buffer absorbs the blur prologue
    fifo #(
        .T     (pixel_t),
        .DEPTH (32)
    ) gray_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (gray_wr_en),
        .din   (gray_din),
        .full  (gray_full),
        .rd_en (gray_rd_en),
        .dout  (gray_dout),
        .empty (gray_empty)
    );

    gaussian_blur gaussian_blur (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (gray_rd_en),
        .in_empty  (gray_empty),
        .in_dout   (gray_dout),
        .out_wr_en (blur_wr_en),
        .out_full  (blur_full),
        .out_din   (blur_din)
    );

    fifo #(
        .T     (pixel_t),
        .DEPTH (8)
    ) out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (blur_wr_en),
        .din   (blur_din),
        .full  (blur_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

`default_nettype wire

//--- tb/blur_tb.sv
`default_nettype none

module blur_tb
    import blur_pkg::*;
();

    localparam int PIXELS = WIDTH * HEIGHT;
    // Longest single wait in clock cycles
    localparam int TIMEOUT = 4000;
    // Quiet window after the last frame
    localparam int DRAIN_CYCLES = 300;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    logic   in_full;
    rgb_t   in_din;
    logic   out_rd_en;
    logic   out_empty;
    pixel_t out_dout;

    // Words still to send and results still expected
    rgb_t   stim_q [$];
    pixel_t expect_q [$];

    // Idle odds in percent for the writer and the reader
    int write_gap_pct;
    int read_stall_pct;
    int checked;

    // Frame under construction
    rgb_t frame [PIXELS];

    blur_top DUT (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_full   (in_full),
        .in_din    (in_din),
        .out_rd_en (out_rd_en),
        .out_empty (out_empty),
        .out_dout  (out_dout)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic abort_run(input string why);
        $display("Error at time %0t: %s", $time, why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            $display("Mismatch at time %0t: output %0d is %0d, expected %0d",
                     $time, checked, got, exp);
            $display("Finished with errors");
            $fatal(1, "pixel value differs");
        end
        checked++;
    endtask

    // Gray conversion then 5x5 blur over in-image taps only
    function automatic void ref_blur(input rgb_t img [PIXELS]);
        int gray [PIXELS];
        int num;
        int den;
        int r;
        int c;
        int q;
        for (int p = 0; p < PIXELS; p++) begin
            gray[p] = (int'(img[p].r) + int'(img[p].g) + int'(img[p].b)) / 3;
        end
        for (int y = 0; y < HEIGHT; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                num = 0;
                den = 0;
                for (int dy = -2; dy <= 2; dy++) begin
                    for (int dx = -2; dx <= 2; dx++) begin
                        r = y + dy;
                        c = x + dx;
                        // Taps off the frame count for nothing
                        if (r >= 0 && r < HEIGHT && c >= 0 && c < WIDTH) begin
                            num += gray[r * WIDTH + c] * int'(KERNEL[dy + 2][dx + 2]);
                            den += int'(KERNEL[dy + 2][dx + 2]);
                        end
                    end
                end
                q = num / den;
                if (q > 255) begin
                    q = 255;
                end
                expect_q.push_back(pixel_t'(q));
            end
        end
    endfunction

    task automatic fill_random();
        for (int p = 0; p < PIXELS; p++) begin
            frame[p] = rgb_t'(24'($urandom));
        end
    endtask

    task automatic fill_constant(input rgb_t value);
        for (int p = 0; p < PIXELS; p++) begin
            frame[p] = value;
        end
    endtask

    // Expected results first and then the words themselves
    task automatic queue_frame();
        ref_blur(frame);
        for (int p = 0; p < PIXELS; p++) begin
            stim_q.push_back(frame[p]);
        end
    endtask

    task automatic send_pixels();
        int waited;
        while (stim_q.size() > 0) begin
            @(negedge clock);
            in_wr_en = 1'b0;
            waited = 0;
            // Hold off while the input FIFO is full
            while (in_full) begin
                waited++;
                if (waited > TIMEOUT) begin
                    abort_run("input FIFO stayed full past the timeout");
                end
                @(negedge clock);
            end
            // Random gaps make the writes bursty
            if (int'($urandom % 100) >= write_gap_pct) begin
                in_din = stim_q.pop_front();
                in_wr_en = 1'b1;
            end
        end
        @(negedge clock);
        in_wr_en = 1'b0;
    endtask

    task automatic receive_pixels(input int count);
        int got_count;
        int idle;
        got_count = 0;
        idle = 0;
        while (got_count < count) begin
            @(negedge clock);
            out_rd_en = 1'b0;
            // Pop the head word unless this cycle stalls
            if (!out_empty && int'($urandom % 100) >= read_stall_pct) begin
                check_pixel(out_dout, expect_q.pop_front());
                out_rd_en = 1'b1;
                got_count++;
                idle = 0;
            end else begin
                idle++;
                if (idle > TIMEOUT) begin
                    abort_run("no output pixel arrived before the timeout");
                end
            end
        end
        @(negedge clock);
        out_rd_en = 1'b0;
    endtask

    task automatic stream(input int gap_pct, input int stall_pct);
        write_gap_pct = gap_pct;
        read_stall_pct = stall_pct;
        fork
            send_pixels();
            receive_pixels(expect_q.size());
        join
    endtask

    // Nothing more may come out once every frame is accounted for
    task automatic confirm_drained();
        for (int n = 0; n < DRAIN_CYCLES; n++) begin
            @(negedge clock);
            if (!out_empty) begin
                abort_run("output FIFO holds a pixel beyond the expected count");
            end
        end
    endtask

    initial begin
        void'($urandom(31282));
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_din = '0;
        out_rd_en = 1'b0;
        write_gap_pct = 0;
        read_stall_pct = 0;
        checked = 0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        // Random frame at full rate
        fill_random();
        queue_frame();
        stream(0, 0);

        // Uniform frame with gray 150 on every pixel
        fill_constant({8'd100, 8'd150, 8'd200});
        queue_frame();
        stream(0, 0);

        // All white frame stays at 255
        fill_constant({8'hff, 8'hff, 8'hff});
        queue_frame();
        stream(0, 0);

        // Bursty writes and stalled reads
        fill_random();
        queue_frame();
        stream(40, 50);

        // Three frames back to back
        repeat (3) begin
            fill_random();
            queue_frame();
        end
        stream(20, 30);

        confirm_drained();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
verilog/blur_pkg.sv
verilog/fifo.sv
verilog/grayscale.sv
verilog/gaussian_blur.sv
verilog/blur_top.sv
tb/blur_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := blur_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0
LINTFLAGS := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the test result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
